/* sources.f */
+incdir+bench
hw/fpmul_pkg.sv
hw/fpmul_unpack.sv
hw/fpmul_row_stage.sv
hw/fpmul_normalize.sv
hw/fpmul_top.sv
bench/tb_fpmul.sv

/* run_sim.sh */
#!/bin/sh
# Builds the multiplier testbench with Verilator, runs it and
# decides the outcome from the simulation log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_fpmul \
    -f sources.f -o tb_fpmul
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_fpmul > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF "** PASS **" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* bench/tb_fpmul_ref.svh */
// ----------------------------------------------------------
// Reference model, random source and value checker
// Needs lfsr_state, checks and errors in the including module
// The model truncates and knows no subnormal operands
// ----------------------------------------------------------
`ifndef TB_FPMUL_REF_SVH
`define TB_FPMUL_REF_SVH

// Expected DUT response for one operand pair
typedef struct packed {
    fpmul_pkg::float32_t     result;
    fpmul_pkg::round_bits_t  rbits;
    fpmul_pkg::fpmul_flags_t flags;
} expect_t;

// 32 bit Fibonacci LFSR with taps 32, 22, 2 and 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// Draws n bits and steps the LFSR once for every bit
function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

// Single-precision multiply with one-step normalization and truncation
function automatic expect_t fpmul_ref(input fpmul_pkg::float32_t a,
                                      input fpmul_pkg::float32_t b);
    expect_t     e;
    logic [47:0] p;
    logic [22:0] frac;
    logic [2:0]  grs;
    int          ex;
    e  = '0;
    p  = {24'd0, 1'b1, a.fraction} * {24'd0, 1'b1, b.fraction};
    ex = int'(a.exponent) + int'(b.exponent) - 127;
    // Leading one at bit 47 means the product is in [2,4)
    if (p[47]) begin
        frac = p[46:24];
        grs  = {p[23], p[22], |p[21:0]};
        ex   = ex + 1;
    end else begin
        frac = p[45:23];
        grs  = {p[22], p[21], |p[20:0]};
    end
    e.result.sign = a.sign ^ b.sign;
    if (a.exponent inside {8'd0, 8'd255} || b.exponent inside {8'd0, 8'd255}) begin
        // Zero, subnormal, infinity and NaN all give the quiet NaN
        e.result        = 32'h7FC00000;
        e.flags.invalid = 1'b1;
    end else if (ex >= 255) begin
        e.result.exponent = 8'hFF;
        e.flags.overflow  = 1'b1;
        e.flags.inexact   = 1'b1;
    end else if (ex <= 0) begin
        e.flags.underflow = 1'b1;
        e.flags.inexact   = 1'b1;
    end else begin
        e.result.exponent = ex[7:0];
        e.result.fraction = frac;
        e.rbits           = grs;
        e.flags.inexact   = |grs;
    end
    return e;
endfunction

// Counts one check and reports it when the values differ
task automatic check_value(input string what, input logic [63:0] got,
                           input logic [63:0] expected);
    checks++;
    if (got !== expected) begin
        errors++;
        $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, expected);
    end
endtask

`endif

/* bench/tb_fpmul.sv */
// ----------------------------------------------------------
// Testbench for the pipelined single-precision multiplier
// Built for NUM_STAGES of 4, so results trail inputs by 6 cycles
// ----------------------------------------------------------
`timescale 1ns/100ps

module tb_fpmul;

    localparam int NUM_STAGES = 4;
    localparam int LATENCY    = NUM_STAGES + 2;
    localparam int TIMEOUT    = 50;
    localparam int N_RANDOM   = 200;

    logic                    clk = 1'b0;
    logic                    rst_n;
    fpmul_pkg::float32_t     a;
    fpmul_pkg::float32_t     b;
    logic                    in_valid;
    fpmul_pkg::float32_t     result;
    fpmul_pkg::round_bits_t  rbits;
    fpmul_pkg::fpmul_flags_t flags;
    logic                    out_valid;

    logic [31:0] lfsr_state = 32'h8ddc68fa;
    int          checks     = 0;
    int          errors     = 0;
    int          cycle      = 0;
    int          send_cycle = 0;
    int          first_out  = -1;
    int          last_out   = -1;
    int          out_count  = 0;

    `include "tb_fpmul_ref.svh"

    // Expected responses in the order the pairs went in
    expect_t exp_q[$];

    always #50 clk = ~clk;
    always @(posedge clk) cycle <= cycle + 1;

    fpmul_top #(.NUM_STAGES(NUM_STAGES)) dut (
        .clk_i    (clk),
        .rst_n_i  (rst_n),
        .a_i      (a),
        .b_i      (b),
        .valid_i  (in_valid),
        .result_o (result),
        .round_o  (rbits),
        .flags_o  (flags),
        .valid_o  (out_valid)
    );

    // ----------------------------------------------------------
    // Stimulus helpers
    // ----------------------------------------------------------
    task automatic send_pair(input logic [31:0] op_a, input logic [31:0] op_b);
        @(posedge clk);
        send_cycle = cycle;
        a        <= op_a;
        b        <= op_b;
        in_valid <= 1'b1;
        exp_q.push_back(fpmul_ref(op_a, op_b));
    endtask

    task automatic go_idle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // Exponents in 64..191 keep most products in the normal range
    function automatic logic [31:0] random_normal();
        logic [31:0] f;
        f[31]    = random_bits(1) == 32'd1;
        f[30:23] = 8'd64 + 8'(random_bits(7));
        f[22:0]  = 23'(random_bits(23));
        return f;
    endfunction

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("Timeout: %0d results missing after %0d cycles", exp_q.size(), TIMEOUT);
            // Results that never came are dropped so the next test starts clean
            exp_q.delete();
        end else begin
            // A few idle cycles catch any extra result
            repeat (3) @(posedge clk);
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        $display("%s: %0d errors", name, errors - err_start);
    endtask

    // ----------------------------------------------------------
    // Checker
    // ----------------------------------------------------------
    // Outputs are sampled on the edge before they change
    always @(posedge clk) begin : compare
        expect_t e;
        if (out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Result at %0t ns arrived with no pair pending", $time);
            end else begin
                e = exp_q.pop_front();
                check_value("result", result, e.result);
                check_value("round bits", rbits, e.rbits);
                check_value("flags", flags, e.flags);
                if (first_out < 0) begin
                    first_out = cycle;
                end
                last_out = cycle;
                out_count++;
            end
        end
    end

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------
    initial begin : main
        logic [31:0] specials [8];
        logic [31:0] x;
        logic [31:0] y;
        expect_t     e;
        int          err_start;
        int          start_cycle;
        rst_n    = 1'b0;
        a        = '0;
        b        = '0;
        in_valid = 1'b0;
        specials = '{32'h00000000, 32'h80000000, 32'h00000001, 32'h807FFFFF,
                     32'h7F800000, 32'hFF800000, 32'h7FC00001, 32'h7F800001};

        // Reset for two edges, then stay idle
        err_start = errors;
        repeat (2) @(posedge clk);
        check_value("valid_o in reset", out_valid, 1'b0);
        rst_n <= 1'b1;
        repeat (10) begin
            @(posedge clk);
            check_value("valid_o while idle", out_valid, 1'b0);
        end
        report_test("Reset and idle", err_start);

        // Random pairs on every cycle
        err_start = errors;
        first_out = -1;
        out_count = 0;
        for (int i = 0; i < N_RANDOM; i++) begin
            x = random_normal();
            y = random_normal();
            send_pair(x, y);
            if (i == 0) start_cycle = send_cycle;
        end
        go_idle();
        wait_drain();
        // The pair is driven one edge before the DUT samples it
        check_value("first output delay", first_out - start_cycle, LATENCY + 1);
        check_value("outputs received", out_count, N_RANDOM);
        check_value("output span", last_out - first_out, N_RANDOM - 1);
        report_test("Latency and back-to-back", err_start);

        // Directed products where 1.5*2.0 gives exactly 3.0
        err_start = errors;
        check_value("model 1.5*2.0", fpmul_ref(32'h3FC00000, 32'h40000000),
                    {32'h40400000, 3'b000, 4'b0000});
        e = fpmul_ref(32'h3F8CCCCD, 32'h40533333);
        check_value("model sticky of 1.1*3.3", e.rbits.sticky, 1'b1);
        send_pair(32'h3FC00000, 32'h40000000);
        send_pair(32'h3FC00000, 32'h3FC00000);
        send_pair(32'h3FA00000, 32'h3FA00000);
        send_pair(32'h3F8CCCCD, 32'h40533333);
        send_pair(32'h3FFFFFFF, 32'hBFFFFFFF);
        go_idle();
        wait_drain();
        report_test("Exact products and round bits", err_start);

        // Exponent sums beyond both ends of the range
        err_start = errors;
        e = fpmul_ref(32'h7F000000, 32'hFF000000);
        check_value("model negative overflow", e.result, 32'hFF800000);
        e = fpmul_ref(32'h80800000, 32'h00800000);
        check_value("model negative underflow", e.result, 32'h80000000);
        send_pair(32'h7F000000, 32'h7F000000);
        send_pair(32'h7F000000, 32'hFF000000);
        send_pair(32'hFF000000, 32'hFF000000);
        send_pair(32'h7F7FFFFF, 32'h40000000);
        send_pair(32'h00800000, 32'h00800000);
        send_pair(32'h80800000, 32'h00800000);
        send_pair(32'h80800000, 32'h80800000);
        send_pair(32'h00800000, 32'h3F000000);
        send_pair(32'h00800000, 32'h3FC00000);
        go_idle();
        wait_drain();
        report_test("Overflow and underflow", err_start);

        // Special operands on each side with normal pairs in between
        err_start = errors;
        for (int i = 0; i < 8; i++) begin
            x = random_normal();
            send_pair(specials[i], x);
            y = random_normal();
            send_pair(x, y);
            send_pair(y, specials[i]);
        end
        go_idle();
        wait_drain();
        report_test("Invalid operands", err_start);

        $display("Done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule : tb_fpmul

/* hw/fpmul_top.sv */
// ----------------------------------------------------------
// Pipelined single-precision multiplier, truncating, no stall
// Latency is NUM_STAGES+2 cycles and NUM_STAGES must divide 24
// Outputs are meaningful only while valid_o is high
// ----------------------------------------------------------
`timescale 1ns/100ps

module fpmul_top #(
    parameter int NUM_STAGES = 4
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  fpmul_pkg::float32_t     a_i,
    input  fpmul_pkg::float32_t     b_i,
    input  logic                    valid_i,
    output fpmul_pkg::float32_t     result_o,
    output fpmul_pkg::round_bits_t  round_o,
    output fpmul_pkg::fpmul_flags_t flags_o,
    output logic                    valid_o
);

    // Multiplier rows handled by every row stage
    localparam int ROWS_PER_STAGE = fpmul_pkg::SIG_W / NUM_STAGES;

    // Elaboration stops if the rows do not split evenly
    if ((fpmul_pkg::SIG_W % NUM_STAGES) != 0) begin : g_bad_stages
        $error("NUM_STAGES must divide the significand width");
    end

    // Link k feeds row stage k and the last link feeds normalize
    fpmul_pkg::mul_pipe_t pipe [NUM_STAGES+1];

    // ----------------------------------------------------------
    // Unpack
    // ----------------------------------------------------------
    fpmul_unpack u_unpack (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .a_i     (a_i),
        .b_i     (b_i),
        .valid_i (valid_i),
        .pipe_o  (pipe[0])
    );

    // ----------------------------------------------------------
    // Array multiplier rows
    // ----------------------------------------------------------
    for (genvar k = 0; k < NUM_STAGES; k++) begin : g_row
        fpmul_row_stage #(
            .ROW_BASE (k * ROWS_PER_STAGE),
            .ROWS     (ROWS_PER_STAGE)
        ) u_row (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .pipe_i  (pipe[k]),
            .pipe_o  (pipe[k+1])
        );
    end

    // ----------------------------------------------------------
    // Normalize and output
    // ----------------------------------------------------------
    fpmul_normalize u_normalize (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .pipe_i   (pipe[NUM_STAGES]),
        .result_o (result_o),
        .round_o  (round_o),
        .flags_o  (flags_o),
        .valid_o  (valid_o)
    );

endmodule : fpmul_top

/* hw/fpmul_normalize.sv */
// ----------------------------------------------------------
// Output stage with one cycle of latency
// Normalizes by at most one place and truncates the fraction
// Results below the normal range flush to a signed zero
// ----------------------------------------------------------
`timescale 1ns/100ps

module fpmul_normalize (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  fpmul_pkg::mul_pipe_t   pipe_i,
    output fpmul_pkg::float32_t    result_o,
    output fpmul_pkg::round_bits_t round_o,
    output fpmul_pkg::fpmul_flags_t flags_o,
    output logic                   valid_o
);

    // ----------------------------------------------------------
    // Single-step normalization
    // ----------------------------------------------------------
    logic [fpmul_pkg::FRAC_W-1:0]        frac;
    fpmul_pkg::round_bits_t              rb_norm;
    logic signed [fpmul_pkg::EXP_W+1:0]  exp_adj;

    // Two significands in [1,2) give a product in [1,4), so the
    // leading one sits at bit 47 or bit 46 and one shift is enough
    always_comb begin
        if (pipe_i.psum[fpmul_pkg::PROD_W-1]) begin
            frac           = pipe_i.psum[46:24];
            rb_norm.guard  = pipe_i.psum[23];
            rb_norm.round  = pipe_i.psum[22];
            rb_norm.sticky = |pipe_i.psum[21:0];
            exp_adj        = $signed(pipe_i.exponent) + 10'sd1;
        end else begin
            frac           = pipe_i.psum[45:23];
            rb_norm.guard  = pipe_i.psum[22];
            rb_norm.round  = pipe_i.psum[21];
            rb_norm.sticky = |pipe_i.psum[20:0];
            exp_adj        = $signed(pipe_i.exponent);
        end
    end

    // ----------------------------------------------------------
    // Special results and flags
    // ----------------------------------------------------------
    fpmul_pkg::float32_t     res_d;
    fpmul_pkg::round_bits_t  rb_d;
    fpmul_pkg::fpmul_flags_t flg_d;

    always_comb begin
        // Start from the ordinary normalized result
        res_d.sign     = pipe_i.sign;
        res_d.exponent = exp_adj[fpmul_pkg::EXP_W-1:0];
        res_d.fraction = frac;
        rb_d           = rb_norm;
        flg_d          = '0;
        flg_d.inexact  = |rb_norm;

        if (pipe_i.invalid) begin
            // Invalid operands override everything else
            res_d         = fpmul_pkg::QNAN;
            rb_d          = '0;
            flg_d         = '0;
            flg_d.invalid = 1'b1;
        end else if (exp_adj >= fpmul_pkg::EXP_MAX) begin
            // Too large for the format so saturate to signed infinity
            res_d.exponent = '1;
            res_d.fraction = '0;
            rb_d           = '0;
            flg_d.overflow = 1'b1;
            flg_d.inexact  = 1'b1;
        end else if (exp_adj <= 0) begin
            // No subnormal results are built so the value is flushed
            res_d.exponent  = '0;
            res_d.fraction  = '0;
            rb_d            = '0;
            flg_d.underflow = 1'b1;
            flg_d.inexact   = 1'b1;
        end
    end

    // ----------------------------------------------------------
    // Output registers
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        result_o <= res_d;
        round_o  <= rb_d;
        flags_o  <= flg_d;
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= pipe_i.valid;
        end
    end

    // Overflow and underflow come from disjoint exponent ranges
    a_no_over_and_under : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        valid_o |-> !(flags_o.overflow && flags_o.underflow)
    );

    // An all-ones exponent on the output is only ever infinity or the NaN
    a_max_exp_flagged : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        valid_o && (result_o.exponent == fpmul_pkg::EXP_W'(fpmul_pkg::EXP_MAX))
            |-> (flags_o.overflow || flags_o.invalid)
    );

endmodule : fpmul_normalize

/* hw/fpmul_row_stage.sv */
// ----------------------------------------------------------
// One registered slice of the array multiplier
// Handles multiplier bits ROW_BASE up to ROW_BASE+ROWS-1
// ROW_BASE+ROWS must not exceed the significand width
// ----------------------------------------------------------
`timescale 1ns/100ps

module fpmul_row_stage #(
    parameter int ROW_BASE = 0,
    parameter int ROWS     = 6
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  fpmul_pkg::mul_pipe_t pipe_i,
    output fpmul_pkg::mul_pipe_t pipe_o
);

    // ----------------------------------------------------------
    // Partial-product accumulation
    // ----------------------------------------------------------
    logic [fpmul_pkg::PROD_W-1:0] a_ext;
    logic [fpmul_pkg::PROD_W-1:0] sum;

    // Multiplicand widened to the product width before shifting
    assign a_ext = fpmul_pkg::PROD_W'(pipe_i.a_sig);

    // Each set multiplier bit adds the multiplicand at that bit's weight
    // The rows of one stage form a short ripple of adders in one cycle
    always_comb begin
        sum = pipe_i.psum;
        for (int r = 0; r < ROWS; r++) begin
            if (pipe_i.b_sig[ROW_BASE + r]) begin
                sum = sum + (a_ext << (ROW_BASE + r));
            end
        end
    end

    // ----------------------------------------------------------
    // Stage register
    // ----------------------------------------------------------
    // Sign, exponent, flags and both significands ride along unchanged
    always_ff @(posedge clk_i) begin
        pipe_o      <= pipe_i;
        pipe_o.psum <= sum;
        if (!rst_n_i) begin
            pipe_o.valid <= 1'b0;
        end
    end

endmodule : fpmul_row_stage

/* hw/fpmul_unpack.sv */
// ----------------------------------------------------------
// Input stage with one cycle of latency
// Zero, subnormal, infinite and NaN operands are all flagged invalid
// The exponent leaves this stage unbiased once and kept signed
// ----------------------------------------------------------
`timescale 1ns/100ps

module fpmul_unpack (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  fpmul_pkg::float32_t  a_i,
    input  fpmul_pkg::float32_t  b_i,
    input  logic                 valid_i,
    output fpmul_pkg::mul_pipe_t pipe_o
);

    // ----------------------------------------------------------
    // Operand classification
    // ----------------------------------------------------------
    logic a_special;
    logic b_special;
    logic pair_invalid;

    // An all-zero exponent covers zero and subnormal inputs
    // An all-ones exponent covers infinity and NaN
    assign a_special = (a_i.exponent == '0) ||
                       (a_i.exponent == fpmul_pkg::EXP_W'(fpmul_pkg::EXP_MAX));
    assign b_special = (b_i.exponent == '0) ||
                       (b_i.exponent == fpmul_pkg::EXP_W'(fpmul_pkg::EXP_MAX));
    assign pair_invalid = a_special || b_special;

    // ----------------------------------------------------------
    // Sign and exponent
    // ----------------------------------------------------------
    logic                                res_sign;
    logic signed [fpmul_pkg::EXP_W+1:0]  exp_sum;

    // Product is negative when exactly one operand is negative
    assign res_sign = a_i.sign ^ b_i.sign;

    // Biased exponents lie in 1..254 for normal inputs, so the sum
    // minus the bias spans -125..381 and fits the 10 bit signed field
    assign exp_sum = $signed({2'b00, a_i.exponent}) +
                     $signed({2'b00, b_i.exponent}) -
                     (fpmul_pkg::EXP_W + 2)'(fpmul_pkg::EXP_BIAS);

    // ----------------------------------------------------------
    // Payload register
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        pipe_o.sign     <= res_sign;
        pipe_o.invalid  <= pair_invalid;
        pipe_o.exponent <= exp_sum;
        // Restore the hidden bit on both significands
        pipe_o.a_sig    <= {1'b1, a_i.fraction};
        pipe_o.b_sig    <= {1'b1, b_i.fraction};
        // The row stages accumulate into a cleared sum
        pipe_o.psum     <= '0;
        if (!rst_n_i) begin
            pipe_o.valid <= 1'b0;
        end else begin
            pipe_o.valid <= valid_i;
        end
    end

    // The strobe has no handshake behind it, so an X here would
    // silently propagate through the whole pipe
    a_valid_known : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown(valid_i)
    );

endmodule : fpmul_unpack

/* hw/fpmul_pkg.sv */
// ----------------------------------------------------------
// Types and constants shared by every multiplier stage
// Only normal operands are multiplied and the result is truncated
// The pipeline payload layout is fixed at 109 bits
// ----------------------------------------------------------
package fpmul_pkg;

    // ----------------------------------------------------------
    // Format widths and constants
    // ----------------------------------------------------------
    localparam int EXP_W    = 8;
    localparam int FRAC_W   = 23;
    // Significand with the hidden bit restored
    localparam int SIG_W    = 24;
    localparam int PROD_W   = 48;
    localparam int EXP_BIAS = 127;
    localparam int EXP_MAX  = 255;

    // IEEE-754 single precision word
    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exponent;
        logic [FRAC_W-1:0] fraction;
    } float32_t;

    // Canonical quiet NaN returned for every invalid pair
    localparam float32_t QNAN = 32'h7FC00000;

    // Bits below the kept fraction, for a rounder further on
    typedef struct packed {
        logic guard;
        logic round;
        logic sticky;
    } round_bits_t;

    // Exception flags, one bit each
    typedef struct packed {
        logic invalid;
        logic inexact;
        logic overflow;
        logic underflow;
    } fpmul_flags_t;

    // ----------------------------------------------------------
    // Pipeline payload
    // ----------------------------------------------------------
    // The exponent is two bits wider than the field and signed so that
    // both overflow and underflow stay visible until the last stage
    typedef struct packed {
        logic                     valid;
        logic                     sign;
        logic                     invalid;
        logic signed [EXP_W+1:0]  exponent;
        logic [SIG_W-1:0]         a_sig;
        logic [SIG_W-1:0]         b_sig;
        logic [PROD_W-1:0]        psum;
    } mul_pipe_t;

endpackage : fpmul_pkg
